// ==== all.f ====
+incdir+logic
logic/fpu_aux_pkg.sv
logic/fpu_fmin_fmax.sv
logic/fpu_int_to_float.sv
logic/fpu_aux_lane.sv
logic/fpu_aux_issue.sv
logic/fpu_aux_retire.sv
logic/fpu_aux_top.sv
test/tb_fpu_aux.sv

// ==== logic/fpu_aux_issue.sv ====
// FPU auxiliary issue stage.
// Four-phase responder on the request port. Captures each request,
// drops illegal ops after acknowledging them, and loads legal ones
// into the lanes in round-robin order.

`timescale 1ns/1ps

`include "fpu_aux_params.svh"

module fpu_aux_issue #(
  parameter int num_lanes_p = `FPU_AUX_NUM_LANES
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  fpu_aux_pkg::fpu_aux_op_e op_i,
  input  fpu_aux_pkg::frm_e        rm_i,
  input  fpu_aux_pkg::fp_word_u    rs1_i,
  input  fpu_aux_pkg::fp_word_u    rs2_i,
  output logic                     ack_o,
  input  logic [num_lanes_p-1:0]   lane_busy_i,
  output logic [num_lanes_p-1:0]   lane_load_o,
  output fpu_aux_pkg::fpu_aux_op_e op_o,
  output fpu_aux_pkg::frm_e        rm_o,
  output fpu_aux_pkg::fp_word_u    rs1_o,
  output fpu_aux_pkg::fp_word_u    rs2_o
);

  localparam int ptr_w_lp = (num_lanes_p > 1) ? $clog2(num_lanes_p) : 1;

  typedef enum logic {
    e_idle,
    e_acked
  } state_e;

  state_e              state_r;
  logic [ptr_w_lp-1:0] ptr_r;
  logic [ptr_w_lp-1:0] ptr_next;
  logic                op_legal;
  logic                accept;

  always_comb begin
    case (op_i)
      fpu_aux_pkg::e_fmin, fpu_aux_pkg::e_fmax,
      fpu_aux_pkg::e_fsgnj, fpu_aux_pkg::e_fsgnjn, fpu_aux_pkg::e_fsgnjx,
      fpu_aux_pkg::e_fcvt_s_w, fpu_aux_pkg::e_fcvt_s_wu,
      fpu_aux_pkg::e_fmv_w_x: op_legal = 1'b1;
      default:                op_legal = 1'b0;
    endcase
  end

  assign accept   = (state_r == e_idle) && req_i && !lane_busy_i[ptr_r];
  assign ptr_next = (ptr_r == ptr_w_lp'(num_lanes_p - 1)) ? '0 : ptr_r + 1'b1;

  // ------------------------------
  // Handshake and dispatch
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r     <= e_idle;
      ptr_r       <= '0;
      lane_load_o <= '0;
    end else begin
      lane_load_o <= '0;
      if (accept) begin
        state_r <= e_acked;
        if (op_legal) begin
          lane_load_o[ptr_r] <= 1'b1;
          ptr_r              <= ptr_next;
        end
      end else if ((state_r == e_acked) && !req_i) begin
        state_r <= e_idle;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o  <= op_i;
      rm_o  <= rm_i;
      rs1_o <= rs1_i;
      rs2_o <= rs2_i;
    end
  end

  assign ack_o = (state_r == e_acked);

  a_ack_needs_req : assert property (
    @(posedge clk_i) disable iff (rst_i) $rose(ack_o) |-> $past(req_i)
  );

  a_one_load : assert property (
    @(posedge clk_i) disable iff (rst_i) $onehot0(lane_load_o)
  );

endmodule

// ==== logic/fpu_aux_lane.sv ====
// FPU auxiliary execution lane.
// Decodes the op, selects the result and flags of one operation,
// and holds them from load until the retire side takes them.

`timescale 1ns/1ps

module fpu_aux_lane (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     load_i,
  input  logic                     take_i,
  input  fpu_aux_pkg::fpu_aux_op_e op_i,
  input  fpu_aux_pkg::frm_e        rm_i,
  input  fpu_aux_pkg::fp_word_u    rs1_i,
  input  fpu_aux_pkg::fp_word_u    rs2_i,
  output logic                     busy_o,
  output logic                     done_o,
  output fpu_aux_pkg::fp_word_u    result_o,
  output fpu_aux_pkg::fflags_s     flags_o
);

  fpu_aux_pkg::fp_word_u minmax_result;
  logic                  minmax_invalid;
  fpu_aux_pkg::fp_word_u cvt_result;
  fpu_aux_pkg::fflags_s  cvt_flags;
  fpu_aux_pkg::fp_word_u sel_result;
  fpu_aux_pkg::fflags_s  sel_flags;
  logic                  full_r;

  fpu_fmin_fmax minmax (
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .fmin_not_fmax_i (op_i == fpu_aux_pkg::e_fmin),
    .result_o        (minmax_result),
    .invalid_o       (minmax_invalid)
  );

  fpu_int_to_float i2f (
    .int_i    (rs1_i.int_v),
    .signed_i (op_i == fpu_aux_pkg::e_fcvt_s_w),
    .rm_i     (rm_i),
    .result_o (cvt_result),
    .flags_o  (cvt_flags)
  );

  // ------------------------------
  // Op decode
  // ------------------------------
  always_comb begin
    sel_result = rs1_i;
    sel_flags  = '0;
    case (op_i)
      fpu_aux_pkg::e_fmin, fpu_aux_pkg::e_fmax: begin
        sel_result        = minmax_result;
        sel_flags.invalid = minmax_invalid;
      end
      fpu_aux_pkg::e_fcvt_s_w, fpu_aux_pkg::e_fcvt_s_wu: begin
        sel_result = cvt_result;
        sel_flags  = cvt_flags;
      end
      fpu_aux_pkg::e_fsgnj:  sel_result.fp.sign = rs2_i.fp.sign;
      fpu_aux_pkg::e_fsgnjn: sel_result.fp.sign = ~rs2_i.fp.sign;
      fpu_aux_pkg::e_fsgnjx: sel_result.fp.sign = rs1_i.fp.sign ^ rs2_i.fp.sign;
      // FMV.W.X passes rs1 through.
      default: ;
    endcase
  end

  // Occupied from load until take.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_r <= 1'b0;
    end else if (load_i) begin
      full_r <= 1'b1;
    end else if (take_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      result_o <= sel_result;
      flags_o  <= sel_flags;
    end
  end

  // Single-cycle compute, so the lane is done as soon as it is busy.
  assign busy_o = full_r;
  assign done_o = full_r;

  // Issue must not overwrite a held result.
  a_no_load_when_busy : assert property (
    @(posedge clk_i) disable iff (rst_i) load_i |-> !busy_o
  );

  // Retire only takes finished lanes.
  a_no_take_without_done : assert property (
    @(posedge clk_i) disable iff (rst_i) take_i |-> done_o
  );

endmodule

// ==== logic/fpu_aux_params.svh ====
// FPU auxiliary unit defaults.
// Lane count and operand width shared by the RTL and the testbench.

`ifndef FPU_AUX_PARAMS_SVH
`define FPU_AUX_PARAMS_SVH

// ------------------------------
// Structure
// ------------------------------

// Number of execution lanes.
`define FPU_AUX_NUM_LANES 4

// ------------------------------
// Data path
// ------------------------------

// Operand and result width in bits.
`define FPU_AUX_DATA_WIDTH 32

`endif

// ==== logic/fpu_aux_pkg.sv ====
// FPU auxiliary unit package.
// Op codes, rounding modes, exception flags and the binary32 operand word.

`include "fpu_aux_params.svh"

package fpu_aux_pkg;

  // Ops handled by the auxiliary unit; other codes are illegal.
  typedef enum logic [3:0] {
    e_fmin      = 4'd0,
    e_fmax      = 4'd1,
    e_fsgnj     = 4'd2,
    e_fsgnjn    = 4'd3,
    e_fsgnjx    = 4'd4,
    e_fcvt_s_w  = 4'd5,
    e_fcvt_s_wu = 4'd6,
    e_fmv_w_x   = 4'd7
  } fpu_aux_op_e;

  // RISC-V rounding modes.
  typedef enum logic [2:0] {
    e_rne = 3'd0,
    e_rtz = 3'd1,
    e_rdn = 3'd2,
    e_rup = 3'd3,
    e_rmm = 3'd4
  } frm_e;

  // Exception flags, fflags bit order.
  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fflags_s;

  // binary32 fields.
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] fraction;
  } fp_fields_s;

  // One operand word, read as an integer or as float fields.
  typedef union packed {
    logic [`FPU_AUX_DATA_WIDTH-1:0] int_v;
    fp_fields_s                     fp;
  } fp_word_u;

  // Quiet NaN returned when no operand is usable.
  localparam fp_word_u canonical_nan = 32'h7fc0_0000;

endpackage

// ==== logic/fpu_aux_retire.sv ====
// FPU auxiliary retire stage.
// Collects lane results in round-robin order and presents each one
// on the four-phase result port, then frees the lane.

`timescale 1ns/1ps

`include "fpu_aux_params.svh"

module fpu_aux_retire #(
  parameter int num_lanes_p = `FPU_AUX_NUM_LANES
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic [num_lanes_p-1:0]                  lane_done_i,
  input  fpu_aux_pkg::fp_word_u [num_lanes_p-1:0] lane_result_i,
  input  fpu_aux_pkg::fflags_s [num_lanes_p-1:0]  lane_flags_i,
  output logic [num_lanes_p-1:0]                  lane_take_o,
  output logic                                    res_req_o,
  output fpu_aux_pkg::fp_word_u                   res_o,
  output fpu_aux_pkg::fflags_s                    res_flags_o,
  input  logic                                    res_ack_i
);

  localparam int ptr_w_lp = (num_lanes_p > 1) ? $clog2(num_lanes_p) : 1;

  typedef enum logic [1:0] {
    e_wait_done,
    e_request,
    e_wait_ack_low
  } state_e;

  state_e              state_r;
  logic [ptr_w_lp-1:0] ptr_r;

  // ------------------------------
  // Result handshake
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r     <= e_wait_done;
      ptr_r       <= '0;
      res_req_o   <= 1'b0;
      lane_take_o <= '0;
    end else begin
      lane_take_o <= '0;
      case (state_r)
        e_wait_done: begin
          if (lane_done_i[ptr_r]) begin
            res_req_o <= 1'b1;
            state_r   <= e_request;
          end
        end
        e_request: begin
          if (res_ack_i) begin
            res_req_o          <= 1'b0;
            lane_take_o[ptr_r] <= 1'b1;
            state_r            <= e_wait_ack_low;
          end
        end
        default: begin
          if (!res_ack_i) begin
            ptr_r   <= (ptr_r == ptr_w_lp'(num_lanes_p - 1)) ? '0 : ptr_r + 1'b1;
            state_r <= e_wait_done;
          end
        end
      endcase
    end
  end

  // Output registers, loaded as the request goes up.
  always_ff @(posedge clk_i) begin
    if ((state_r == e_wait_done) && lane_done_i[ptr_r]) begin
      res_o       <= lane_result_i[ptr_r];
      res_flags_o <= lane_flags_i[ptr_r];
    end
  end

  a_res_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (res_req_o && !res_ack_i) |=> ($stable(res_o) && $stable(res_flags_o))
  );

endmodule

// ==== logic/fpu_aux_top.sv ====
// FPU auxiliary unit top level.
// Issue stage, a row of identical execution lanes and the retire stage.

`timescale 1ns/1ps

`include "fpu_aux_params.svh"

module fpu_aux_top #(
  parameter int num_lanes_p = `FPU_AUX_NUM_LANES
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  fpu_aux_pkg::fpu_aux_op_e op_i,
  input  fpu_aux_pkg::frm_e        rm_i,
  input  fpu_aux_pkg::fp_word_u    rs1_i,
  input  fpu_aux_pkg::fp_word_u    rs2_i,
  output logic                     ack_o,
  output logic                     res_req_o,
  output fpu_aux_pkg::fp_word_u    res_o,
  output fpu_aux_pkg::fflags_s     res_flags_o,
  input  logic                     res_ack_i
);

  logic [num_lanes_p-1:0]                  lane_busy;
  logic [num_lanes_p-1:0]                  lane_load;
  logic [num_lanes_p-1:0]                  lane_done;
  logic [num_lanes_p-1:0]                  lane_take;
  fpu_aux_pkg::fp_word_u [num_lanes_p-1:0] lane_result;
  fpu_aux_pkg::fflags_s [num_lanes_p-1:0]  lane_flags;
  fpu_aux_pkg::fpu_aux_op_e                iss_op;
  fpu_aux_pkg::frm_e                       iss_rm;
  fpu_aux_pkg::fp_word_u                   iss_rs1;
  fpu_aux_pkg::fp_word_u                   iss_rs2;

  fpu_aux_issue #(.num_lanes_p(num_lanes_p)) issue (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .rm_i        (rm_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .ack_o       (ack_o),
    .lane_busy_i (lane_busy),
    .lane_load_o (lane_load),
    .op_o        (iss_op),
    .rm_o        (iss_rm),
    .rs1_o       (iss_rs1),
    .rs2_o       (iss_rs2)
  );

  for (genvar i = 0; i < num_lanes_p; i++) begin : g_lane
    fpu_aux_lane lane (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .load_i   (lane_load[i]),
      .take_i   (lane_take[i]),
      .op_i     (iss_op),
      .rm_i     (iss_rm),
      .rs1_i    (iss_rs1),
      .rs2_i    (iss_rs2),
      .busy_o   (lane_busy[i]),
      .done_o   (lane_done[i]),
      .result_o (lane_result[i]),
      .flags_o  (lane_flags[i])
    );
  end

  fpu_aux_retire #(.num_lanes_p(num_lanes_p)) retire (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_done_i   (lane_done),
    .lane_result_i (lane_result),
    .lane_flags_i  (lane_flags),
    .lane_take_o   (lane_take),
    .res_req_o     (res_req_o),
    .res_o         (res_o),
    .res_flags_o   (res_flags_o),
    .res_ack_i     (res_ack_i)
  );

endmodule

// ==== logic/fpu_fmin_fmax.sv ====
// FMIN / FMAX for binary32.
// Orders operands by sign then magnitude, -0 below +0.
// A single NaN operand yields the other one, two NaNs the canonical NaN.
// Signaling NaN inputs raise invalid.

`timescale 1ns/1ps

`include "fpu_aux_params.svh"

module fpu_fmin_fmax (
  input  fpu_aux_pkg::fp_word_u rs1_i,
  input  fpu_aux_pkg::fp_word_u rs2_i,
  input  logic                  fmin_not_fmax_i,
  output fpu_aux_pkg::fp_word_u result_o,
  output logic                  invalid_o
);

  logic rs1_nan;
  logic rs2_nan;
  logic rs1_snan;
  logic rs2_snan;
  logic mag_lt;
  logic rs1_lt_rs2;

  assign rs1_nan  = (rs1_i.fp.exponent == 8'hff) && (rs1_i.fp.fraction != '0);
  assign rs2_nan  = (rs2_i.fp.exponent == 8'hff) && (rs2_i.fp.fraction != '0);
  assign rs1_snan = rs1_nan && !rs1_i.fp.fraction[22];
  assign rs2_snan = rs2_nan && !rs2_i.fp.fraction[22];

  // Magnitude compare on everything below the sign.
  assign mag_lt = rs1_i.int_v[`FPU_AUX_DATA_WIDTH-2:0] < rs2_i.int_v[`FPU_AUX_DATA_WIDTH-2:0];

  // Sign first, so -0 sorts below +0.
  always_comb begin
    if (rs1_i.fp.sign != rs2_i.fp.sign) begin
      rs1_lt_rs2 = rs1_i.fp.sign;
    end else if (rs1_i.fp.sign) begin
      rs1_lt_rs2 = !mag_lt && (rs1_i.int_v != rs2_i.int_v);
    end else begin
      rs1_lt_rs2 = mag_lt;
    end
  end

  always_comb begin
    if (rs1_nan && rs2_nan) begin
      result_o = fpu_aux_pkg::canonical_nan;
    end else if (rs1_nan) begin
      result_o = rs2_i;
    end else if (rs2_nan) begin
      result_o = rs1_i;
    end else if (fmin_not_fmax_i) begin
      result_o = rs1_lt_rs2 ? rs1_i : rs2_i;
    end else begin
      result_o = rs1_lt_rs2 ? rs2_i : rs1_i;
    end
  end

  assign invalid_o = rs1_snan | rs2_snan;

endmodule

// ==== logic/fpu_int_to_float.sv ====
// Integer to binary32 conversion.
// Signed or unsigned input, normalized by a leading-zero count,
// then rounded to 24 significand bits under the given rounding mode.
// Only inexact can be raised.

`timescale 1ns/1ps

`include "fpu_aux_params.svh"

module fpu_int_to_float (
  input  logic [`FPU_AUX_DATA_WIDTH-1:0] int_i,
  input  logic                           signed_i,
  input  fpu_aux_pkg::frm_e              rm_i,
  output fpu_aux_pkg::fp_word_u          result_o,
  output fpu_aux_pkg::fflags_s           flags_o
);

  localparam int w_lp    = `FPU_AUX_DATA_WIDTH;
  localparam int lz_w_lp = $clog2(w_lp);

  logic               neg;
  logic [w_lp-1:0]    mag;
  logic [lz_w_lp-1:0] lz;
  logic [w_lp-1:0]    norm;
  logic [23:0]        sig;
  logic               guard;
  logic               sticky;
  logic               round_up;
  logic [24:0]        sig_rnd;
  logic [7:0]         exp_raw;

  assign neg = signed_i & int_i[w_lp-1];
  assign mag = neg ? (~int_i + 1'b1) : int_i;

  // Leading zero count; the highest set bit wins.
  always_comb begin
    lz = '0;
    for (int i = 0; i < w_lp; i++) begin
      if (mag[i]) begin
        lz = lz_w_lp'(w_lp - 1 - i);
      end
    end
  end

  assign norm   = mag << lz;
  assign sig    = norm[w_lp-1 -: 24];
  assign guard  = norm[w_lp-25];
  assign sticky = |norm[w_lp-26:0];

  // Biased exponent of the leading one.
  assign exp_raw = 8'(127 + w_lp - 1 - int'(lz));

  // ------------------------------
  // Rounding
  // ------------------------------
  always_comb begin
    case (rm_i)
      fpu_aux_pkg::e_rtz: round_up = 1'b0;
      fpu_aux_pkg::e_rdn: round_up = neg & (guard | sticky);
      fpu_aux_pkg::e_rup: round_up = ~neg & (guard | sticky);
      fpu_aux_pkg::e_rmm: round_up = guard;
      default:            round_up = guard & (sticky | sig[0]);
    endcase
  end

  assign sig_rnd = {1'b0, sig} + 25'(round_up);

  // Carry out of the significand moves up one binade.
  always_comb begin
    result_o = '0;
    if (mag != '0) begin
      result_o.fp.sign = neg;
      if (sig_rnd[24]) begin
        result_o.fp.exponent = exp_raw + 8'd1;
        result_o.fp.fraction = sig_rnd[23:1];
      end else begin
        result_o.fp.exponent = exp_raw;
        result_o.fp.fraction = sig_rnd[22:0];
      end
    end
  end

  always_comb begin
    flags_o         = '0;
    flags_o.inexact = guard | sticky;
  end

endmodule

// ==== test/tb_fpu_aux.sv ====
// FPU auxiliary unit testbench.
// Directed tests for sign injection, move, min/max, integer conversion,
// illegal ops, back-pressure with in-order retire, and reset state.
// Expected values come from a behavioral model of the binary32 rules.

`timescale 1ns/1ps

`include "fpu_aux_params.svh"

module tb_fpu_aux;

  localparam int timeout_lp = 100;

  logic                            clk_i;
  logic                            rst_i;
  logic                            req_i;
  fpu_aux_pkg::fpu_aux_op_e        op_i;
  fpu_aux_pkg::frm_e               rm_i;
  fpu_aux_pkg::fp_word_u           rs1_i;
  fpu_aux_pkg::fp_word_u           rs2_i;
  logic                            ack_o;
  logic                            res_req_o;
  fpu_aux_pkg::fp_word_u           res_o;
  fpu_aux_pkg::fflags_s            res_flags_o;
  logic                            res_ack_i;

  int                              errors;
  int                              checks;
  integer                          seed;
  fpu_aux_pkg::fp_word_u           exp_words[$];
  fpu_aux_pkg::fflags_s            exp_flags[$];

  fpu_aux_top dut_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .rm_i        (rm_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .ack_o       (ack_o),
    .res_req_o   (res_req_o),
    .res_o       (res_o),
    .res_flags_o (res_flags_o),
    .res_ack_i   (res_ack_i)
  );

  always #2 clk_i = ~clk_i;

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_word(input string name, input fpu_aux_pkg::fp_word_u exp_v,
                            input fpu_aux_pkg::fp_word_u act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("Fail t=%0t %s: expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_flags(input string name, input fpu_aux_pkg::fflags_s exp_v,
                             input fpu_aux_pkg::fflags_s act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("Fail t=%0t %s: expected %b, got %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("Fail t=%0t %s: expected %b, got %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("At t=%0t: %s", $time, what);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic is_nan(input fpu_aux_pkg::fp_word_u w);
    return (w.fp.exponent == 8'hff) && (w.fp.fraction != 23'd0);
  endfunction

  // Order key where negative values are flipped so -0 sorts under +0.
  function automatic logic [31:0] order_key(input fpu_aux_pkg::fp_word_u w);
    return w.fp.sign ? ~w.int_v : (w.int_v | 32'h8000_0000);
  endfunction

  task automatic convert_int(input logic [31:0] a, input logic is_signed,
                             input fpu_aux_pkg::frm_e rm, output fpu_aux_pkg::fp_word_u res,
                             output fpu_aux_pkg::fflags_s fl);
    longint sv;
    longint mag;
    longint kept;
    longint rem;
    longint half;
    logic   neg;
    logic   up;
    int     p;
    int     shift;
    res  = '0;
    fl   = '0;
    sv   = $signed(a);
    neg  = is_signed && a[31];
    mag  = neg ? -sv : longint'(a);
    rem  = 0;
    p    = 0;
    if (mag != 0) begin
      for (int i = 0; i < 32; i++) begin
        if (mag[i]) p = i;
      end
      if (p <= 23) begin
        kept = mag << (23 - p);
      end else begin
        shift = p - 23;
        kept  = mag >> shift;
        rem   = mag - (kept << shift);
        half  = longint'(1) << (shift - 1);
        case (rm)
          fpu_aux_pkg::e_rtz: up = 1'b0;
          fpu_aux_pkg::e_rdn: up = neg && (rem != 0);
          fpu_aux_pkg::e_rup: up = !neg && (rem != 0);
          fpu_aux_pkg::e_rmm: up = rem >= half;
          default:            up = (rem > half) || ((rem == half) && kept[0]);
        endcase
        if (up) kept = kept + 1;
        if (kept == (longint'(1) << 24)) begin
          kept = kept >> 1;
          p    = p + 1;
        end
      end
      res.fp.sign     = neg;
      res.fp.exponent = 8'(127 + p);
      res.fp.fraction = kept[22:0];
    end
    fl.inexact = (rem != 0);
  endtask

  task automatic model_op(input fpu_aux_pkg::fpu_aux_op_e op, input fpu_aux_pkg::frm_e rm,
                          input fpu_aux_pkg::fp_word_u a, input fpu_aux_pkg::fp_word_u b,
                          output fpu_aux_pkg::fp_word_u res, output fpu_aux_pkg::fflags_s fl);
    logic a_lower;
    res     = a;
    fl      = '0;
    a_lower = order_key(a) < order_key(b);
    case (op)
      fpu_aux_pkg::e_fmin, fpu_aux_pkg::e_fmax: begin
        if (is_nan(a) && is_nan(b)) res = fpu_aux_pkg::canonical_nan;
        else if (is_nan(a)) res = b;
        else if (is_nan(b)) res = a;
        else if (op == fpu_aux_pkg::e_fmin) res = a_lower ? a : b;
        else res = a_lower ? b : a;
        fl.invalid = (is_nan(a) && !a.fp.fraction[22]) || (is_nan(b) && !b.fp.fraction[22]);
      end
      fpu_aux_pkg::e_fsgnj:  res.fp.sign = b.fp.sign;
      fpu_aux_pkg::e_fsgnjn: res.fp.sign = !b.fp.sign;
      fpu_aux_pkg::e_fsgnjx: res.fp.sign = a.fp.sign ^ b.fp.sign;
      fpu_aux_pkg::e_fcvt_s_w:  convert_int(a.int_v, 1'b1, rm, res, fl);
      fpu_aux_pkg::e_fcvt_s_wu: convert_int(a.int_v, 1'b0, rm, res, fl);
      default: ;
    endcase
  endtask

  // ------------------------------
  // Handshake drivers
  // ------------------------------
  task automatic start_req(input fpu_aux_pkg::fpu_aux_op_e op, input fpu_aux_pkg::frm_e rm,
                           input fpu_aux_pkg::fp_word_u a, input fpu_aux_pkg::fp_word_u b);
    @(negedge clk_i);
    op_i  = op;
    rm_i  = rm;
    rs1_i = a;
    rs2_i = b;
    req_i = 1'b1;
  endtask

  task automatic finish_req();
    int n;
    n = 0;
    while (!ack_o && n < timeout_lp) begin
      @(negedge clk_i);
      n++;
    end
    if (!ack_o) report_problem("Request was never acknowledged");
    req_i = 1'b0;
    n = 0;
    while (ack_o && n < timeout_lp) begin
      @(negedge clk_i);
      n++;
    end
    if (ack_o) report_problem("Acknowledge stayed high after the request dropped");
  endtask

  task automatic send_req(input fpu_aux_pkg::fpu_aux_op_e op, input fpu_aux_pkg::frm_e rm,
                          input fpu_aux_pkg::fp_word_u a, input fpu_aux_pkg::fp_word_u b);
    start_req(op, rm, a, b);
    finish_req();
  endtask

  task automatic recv_result();
    int                    n;
    fpu_aux_pkg::fp_word_u w;
    fpu_aux_pkg::fflags_s  f;
    n = 0;
    while (!res_req_o && n < timeout_lp) begin
      @(negedge clk_i);
      n++;
    end
    if (!res_req_o) begin
      report_problem("No result was presented");
    end else if (exp_words.size() == 0) begin
      report_problem("A result arrived that was not expected");
    end else begin
      w = exp_words.pop_front();
      f = exp_flags.pop_front();
      check_word("res_o", w, res_o);
      check_flags("res_flags_o", f, res_flags_o);
    end
    res_ack_i = 1'b1;
    n = 0;
    while (res_req_o && n < timeout_lp) begin
      @(negedge clk_i);
      n++;
    end
    if (res_req_o) report_problem("Result request stayed high after acknowledge");
    res_ack_i = 1'b0;
  endtask

  task automatic expect_op(input fpu_aux_pkg::fpu_aux_op_e op, input fpu_aux_pkg::frm_e rm,
                           input fpu_aux_pkg::fp_word_u a, input fpu_aux_pkg::fp_word_u b);
    fpu_aux_pkg::fp_word_u w;
    fpu_aux_pkg::fflags_s  f;
    model_op(op, rm, a, b, w, f);
    exp_words.push_back(w);
    exp_flags.push_back(f);
  endtask

  task automatic run_op(input fpu_aux_pkg::fpu_aux_op_e op, input fpu_aux_pkg::frm_e rm,
                        input logic [31:0] a, input logic [31:0] b);
    expect_op(op, rm, a, b);
    send_req(op, rm, a, b);
    recv_result();
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic reset_outputs_low();
    repeat (10) begin
      @(negedge clk_i);
      check_bit("ack_o", 1'b0, ack_o);
      check_bit("res_req_o", 1'b0, res_req_o);
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    check_bit("ack_o", 1'b0, ack_o);
    check_bit("res_req_o", 1'b0, res_req_o);
  endtask

  task automatic sign_inject_and_move();
    logic [31:0] a_v[4] = '{32'h3f80_0000, 32'h7fc0_0000, 32'hff80_0001, 32'h8000_0000};
    logic [31:0] b_v[4] = '{32'hbf80_0000, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000};
    for (int i = 0; i < 4; i++) begin
      run_op(fpu_aux_pkg::e_fsgnj, fpu_aux_pkg::e_rne, a_v[i], b_v[i]);
      run_op(fpu_aux_pkg::e_fsgnjn, fpu_aux_pkg::e_rne, a_v[i], b_v[i]);
      run_op(fpu_aux_pkg::e_fsgnjx, fpu_aux_pkg::e_rne, a_v[i], b_v[i]);
      run_op(fpu_aux_pkg::e_fmv_w_x, fpu_aux_pkg::e_rne, a_v[i], b_v[i]);
    end
  endtask

  task automatic min_max_cases();
    logic [31:0] a_v[11] = '{32'h8000_0000, 32'h0000_0000, 32'h7fc0_0000, 32'hc000_0000,
                             32'h7fc0_0000, 32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000,
                             32'h4040_0000, 32'hc040_0000, 32'hbf80_0000};
    logic [31:0] b_v[11] = '{32'h0000_0000, 32'h8000_0000, 32'h4040_0000, 32'h7fc0_0001,
                             32'hffc0_0000, 32'h3f80_0000, 32'hbf80_0000, 32'h4040_0000,
                             32'h3f80_0000, 32'hbf80_0000, 32'hc040_0000};
    for (int i = 0; i < 11; i++) begin
      run_op(fpu_aux_pkg::e_fmin, fpu_aux_pkg::e_rne, a_v[i], b_v[i]);
      run_op(fpu_aux_pkg::e_fmax, fpu_aux_pkg::e_rne, a_v[i], b_v[i]);
    end
  endtask

  task automatic int_conversions();
    logic [31:0] vals[11];
    vals[0] = 32'h0;
    vals[1] = 32'h1;
    vals[2] = 32'hffff_ffff;
    vals[3] = 32'h7fff_ffff;
    vals[4] = 32'h8000_0000;
    vals[5] = 32'h0100_0003;
    vals[6] = 32'h00ff_ffff;
    for (int i = 7; i < 11; i++) begin
      vals[i] = $random(seed);
    end
    for (int i = 0; i < 11; i++) begin
      for (int m = 0; m < 5; m++) begin
        run_op(fpu_aux_pkg::e_fcvt_s_w, fpu_aux_pkg::frm_e'(m), vals[i], 32'h0);
        run_op(fpu_aux_pkg::e_fcvt_s_wu, fpu_aux_pkg::frm_e'(m), vals[i], 32'h0);
      end
    end
  endtask

  task automatic illegal_op_dropped();
    int n;
    send_req(fpu_aux_pkg::fpu_aux_op_e'(4'hc), fpu_aux_pkg::e_rne, 32'h1234_5678, 32'h0);
    for (n = 0; n < timeout_lp; n++) begin
      @(negedge clk_i);
      if (res_req_o) begin
        report_problem("An illegal op produced a result");
        break;
      end
    end
    run_op(fpu_aux_pkg::e_fsgnjn, fpu_aux_pkg::e_rne, 32'h4049_0fdb, 32'h0);
  endtask

  task automatic back_pressure_order();
    logic [31:0] a_v[6] = '{32'h3f80_0000, 32'h0000_0007, 32'hc120_0000, 32'hffff_fff0,
                            32'h7fc0_0000, 32'h0123_4567};
    fpu_aux_pkg::fpu_aux_op_e ops[6] = '{fpu_aux_pkg::e_fsgnjn, fpu_aux_pkg::e_fcvt_s_w,
                                         fpu_aux_pkg::e_fmax, fpu_aux_pkg::e_fcvt_s_w,
                                         fpu_aux_pkg::e_fmin, fpu_aux_pkg::e_fmv_w_x};
    for (int i = 0; i < `FPU_AUX_NUM_LANES; i++) begin
      expect_op(ops[i], fpu_aux_pkg::e_rne, a_v[i], 32'h4000_0000);
      send_req(ops[i], fpu_aux_pkg::e_rne, a_v[i], 32'h4000_0000);
    end
    // All lanes hold results, so this request has to wait.
    expect_op(ops[4], fpu_aux_pkg::e_rne, a_v[4], 32'h4000_0000);
    start_req(ops[4], fpu_aux_pkg::e_rne, a_v[4], 32'h4000_0000);
    repeat (20) begin
      @(negedge clk_i);
      check_bit("ack_o", 1'b0, ack_o);
    end
    recv_result();
    finish_req();
    recv_result();
    expect_op(ops[5], fpu_aux_pkg::e_rne, a_v[5], 32'h4000_0000);
    send_req(ops[5], fpu_aux_pkg::e_rne, a_v[5], 32'h4000_0000);
    repeat (4) recv_result();
    if (exp_words.size() != 0) report_problem("Some results never arrived");
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    req_i     = 1'b0;
    op_i      = fpu_aux_pkg::e_fmin;
    rm_i      = fpu_aux_pkg::e_rne;
    rs1_i     = '0;
    rs2_i     = '0;
    res_ack_i = 1'b0;
    errors    = 0;
    checks    = 0;
    seed      = 32'hd8f2;

    reset_outputs_low();
    sign_inject_and_move();
    min_max_cases();
    int_conversions();
    illegal_op_dropped();
    back_pressure_order();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
